// File: source/trellis_pkg.sv
package trellis_pkg;

	// rate 1/2, constraint length 3
	localparam int num_states = 4;
	localparam int state_width = 2;
	localparam int symbol_width = 2;

	// octal 7 and 5, msb taps the newest input bit
	localparam logic [2:0] generator_0 = 3'o7;
	localparam logic [2:0] generator_1 = 3'o5;

	// hamming distance of one symbol pair is 0 to 2
	localparam int branch_metric_width = 2;
	localparam int max_branch_metric = 2;

	// newest bit in the high position
	typedef enum logic [state_width-1:0] {
		state_00 = 2'b00,
		state_01 = 2'b01,
		state_10 = 2'b10,
		state_11 = 2'b11
	} trellis_state_t;

	typedef logic [symbol_width-1:0] symbol_t;

	// state that reaches target when its old low bit was low_bit
	function automatic trellis_state_t predecessor(trellis_state_t target, logic low_bit);
		return trellis_state_t'({target[0], low_bit});
	endfunction

	// code symbol emitted on the transition from state on input bit_in
	function automatic symbol_t encode(trellis_state_t state, logic bit_in);
		logic [2:0] shift_reg;
		shift_reg = {bit_in, state};
		return {^(shift_reg & generator_0), ^(shift_reg & generator_1)};
	endfunction

	function automatic logic [branch_metric_width-1:0] branch_metric(symbol_t received,
			symbol_t expected);
		symbol_t diff;
		diff = received ^ expected;
		return {1'b0, diff[1]} + {1'b0, diff[0]};
	endfunction

endpackage

// File: source/pipeline_pkg.sv
package pipeline_pkg;

	localparam int num_columns = 8;
	localparam int metric_width = 7;
	localparam int tag_width = 3;

	// largest value a path metric register can hold
	localparam int max_metric = 2 ** metric_width - 1;

	typedef logic [metric_width-1:0] metric_t;
	typedef logic [tag_width-1:0] block_tag_t;

	// survivor address then decision bit, as on the decision bus
	typedef struct packed {
		trellis_pkg::trellis_state_t survivor;
		logic decision;
	} state_decision_t;

	// tag, then states 3 down to 0
	typedef struct packed {
		block_tag_t tag;
		state_decision_t [trellis_pkg::num_states-1:0] decisions;
	} column_decision_t;

	// everything a block carries from one column to the next
	typedef struct packed {
		logic valid;
		block_tag_t tag;
		metric_t [trellis_pkg::num_states-1:0] metrics;
		trellis_pkg::symbol_t [num_columns-1:0] symbols;
	} column_stage_t;

endpackage

// File: source/acs_unit.sv
`timescale 1ns/100ps

module acs_unit (
	input trellis_pkg::trellis_state_t state,
	input trellis_pkg::symbol_t symbol,
	input pipeline_pkg::metric_t metric_low,
	input pipeline_pkg::metric_t metric_high,
	output pipeline_pkg::metric_t metric,
	output pipeline_pkg::state_decision_t choice
);

	trellis_pkg::trellis_state_t pred_low;
	trellis_pkg::trellis_state_t pred_high;
	trellis_pkg::symbol_t code_low;
	trellis_pkg::symbol_t code_high;
	logic [trellis_pkg::branch_metric_width-1:0] dist_low;
	logic [trellis_pkg::branch_metric_width-1:0] dist_high;
	pipeline_pkg::metric_t sum_low;
	pipeline_pkg::metric_t sum_high;
	logic take_high;

	// both predecessors share their high bit with our low bit
	assign pred_low = trellis_pkg::predecessor(state, 1'b0);
	assign pred_high = trellis_pkg::predecessor(state, 1'b1);

	// input bit of the transition is the new high state bit
	assign code_low = trellis_pkg::encode(pred_low, state[1]);
	assign code_high = trellis_pkg::encode(pred_high, state[1]);

	assign dist_low = trellis_pkg::branch_metric(symbol, code_low);
	assign dist_high = trellis_pkg::branch_metric(symbol, code_high);

	// add
	assign sum_low = metric_low + pipeline_pkg::metric_t'(dist_low);
	assign sum_high = metric_high + pipeline_pkg::metric_t'(dist_high);

	// compare, ties stay with the low predecessor
	assign take_high = sum_high < sum_low;

	// select
	always_comb begin
		if (take_high) begin
			metric = sum_high;
			choice.survivor = pred_high;
		end else begin
			metric = sum_low;
			choice.survivor = pred_low;
		end
		choice.decision = choice.survivor[0];
	end

endmodule

// File: source/acs_column.sv
`timescale 1ns/100ps

module acs_column #(
	parameter int unsigned column_index = 0
) (
	input logic clk,
	input logic reset,
	input pipeline_pkg::column_stage_t stage_in,
	output pipeline_pkg::column_stage_t stage_out,
	output pipeline_pkg::column_decision_t decision,
	output logic decision_valid
);

	pipeline_pkg::metric_t [trellis_pkg::num_states-1:0] next_metrics;
	pipeline_pkg::state_decision_t [trellis_pkg::num_states-1:0] choices;

	logic valid_q;
	pipeline_pkg::block_tag_t tag_q;
	pipeline_pkg::metric_t [trellis_pkg::num_states-1:0] metrics_q;
	trellis_pkg::symbol_t [pipeline_pkg::num_columns-1:0] symbols_q;
	pipeline_pkg::state_decision_t [trellis_pkg::num_states-1:0] decisions_q;

	for (genvar n = 0; n < trellis_pkg::num_states; n++) begin : gen_state
		// states n and n+2 read the pair whose high bit is n[0]
		localparam int pair_base = (n % 2) * 2;

		acs_unit u_acs_unit (
			.state(trellis_pkg::trellis_state_t'(n)),
			.symbol(stage_in.symbols[column_index]),
			.metric_low(stage_in.metrics[pair_base]),
			.metric_high(stage_in.metrics[pair_base + 1]),
			.metric(next_metrics[n]),
			.choice(choices[n])
		);

		// incoming metric plus the worst branch must still fit
		assert property (@(posedge clk) disable iff (reset)
			stage_in.valid |->
				stage_in.metrics[n] <=
					pipeline_pkg::max_metric - trellis_pkg::max_branch_metric)
			else $error("column %0d state %0d metric would overflow", column_index, n);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= stage_in.valid;
		end
	end

	// payload moves only with a block
	always_ff @(posedge clk) begin
		if (stage_in.valid) begin
			tag_q <= stage_in.tag;
			metrics_q <= next_metrics;
			symbols_q <= stage_in.symbols;
			decisions_q <= choices;
		end
	end

	assign stage_out.valid = valid_q;
	assign stage_out.tag = tag_q;
	assign stage_out.metrics = metrics_q;
	assign stage_out.symbols = symbols_q;

	assign decision.tag = tag_q;
	assign decision.decisions = decisions_q;
	assign decision_valid = valid_q;

	// a published word always belongs to a known block
	assert property (@(posedge clk) disable iff (reset)
		decision_valid |-> !$isunknown(decision.tag))
		else $error("column %0d published an unknown tag", column_index);

	// one cycle through the column, tag carried along with it
	assert property (@(posedge clk) disable iff (reset)
		1'b1 |=> decision_valid == $past(stage_in.valid)
			&& (!decision_valid || decision.tag == $past(stage_in.tag)))
		else $error("column %0d valid or tag out of step with its input", column_index);

endmodule

// File: source/viterbi_acs_array.sv
`timescale 1ns/100ps

module viterbi_acs_array (
	input logic clk,
	input logic reset,
	input logic input_valid,
	input pipeline_pkg::block_tag_t block_tag,
	input trellis_pkg::symbol_t [pipeline_pkg::num_columns-1:0] block_symbols,
	output pipeline_pkg::column_decision_t [pipeline_pkg::num_columns-1:0] column_decisions,
	output logic [pipeline_pkg::num_columns-1:0] column_valid,
	output pipeline_pkg::metric_t [trellis_pkg::num_states-1:0] path_metrics
);

	// stage k feeds column k, the last one is the array output
	pipeline_pkg::column_stage_t stages [0:pipeline_pkg::num_columns];

	// first column starts every path at zero
	assign stages[0].valid = input_valid;
	assign stages[0].tag = block_tag;
	assign stages[0].metrics = '0;
	assign stages[0].symbols = block_symbols;

	for (genvar k = 0; k < pipeline_pkg::num_columns; k++) begin : gen_column
		acs_column #(
			.column_index(k)
		) u_acs_column (
			.clk(clk),
			.reset(reset),
			.stage_in(stages[k]),
			.stage_out(stages[k + 1]),
			.decision(column_decisions[k]),
			.decision_valid(column_valid[k])
		);
	end

	// valid together with column_valid of the last column
	assign path_metrics = stages[pipeline_pkg::num_columns].metrics;

endmodule

// File: test/decision_checker.sv
`timescale 1ns/100ps

module decision_checker (
	input logic clk,
	input logic reset,
	input pipeline_pkg::column_decision_t [pipeline_pkg::num_columns-1:0] column_decisions,
	input logic [pipeline_pkg::num_columns-1:0] column_valid,
	input pipeline_pkg::metric_t [trellis_pkg::num_states-1:0] path_metrics,
	output logic [7:0] busy_tags,
	output int pass_count,
	output int fail_count,
	output int error_count
);

	string slot_name [8];
	logic [7:0][11:0] slot_words [8];
	logic [3:0][6:0] slot_metrics [8];
	int slot_accept [8];
	int slot_next [8];
	logic slot_bad [8];
	int cycle = 0;
	logic reset_q = 1'b0;

	initial begin
		busy_tags = '0;
		pass_count = 0;
		fail_count = 0;
		error_count = 0;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		reset_q <= reset;
	end

	// block is sampled by the DUT on the next rising edge
	task automatic expect_block(input string name, input logic [2:0] tag,
			input logic [7:0][11:0] words, input logic [3:0][6:0] metrics);
		if (busy_tags[tag]) begin
			$display("tag %0d reused while block %s is in flight", tag, slot_name[tag]);
			error_count++;
		end
		slot_name[tag] = name;
		slot_words[tag] = words;
		slot_metrics[tag] = metrics;
		// cycle in which the block sits on the DUT inputs
		slot_accept[tag] = cycle;
		slot_next[tag] = 0;
		slot_bad[tag] = 1'b0;
		busy_tags[tag] = 1'b1;
	endtask

	task automatic finish_block(input int tag);
		if (slot_bad[tag]) begin
			fail_count++;
			$display("FAIL %s (tag %0d)", slot_name[tag], tag);
		end else begin
			pass_count++;
			$display("PASS %s (tag %0d)", slot_name[tag], tag);
		end
		busy_tags[tag] = 1'b0;
	endtask

	task automatic check_column(input int k);
		int tag;
		logic [14:0] expected;
		tag = column_decisions[k].tag;
		if (!busy_tags[tag]) begin
			$display("unexpected column_valid[%0d] pulse with tag %0d", k, tag);
			error_count++;
			return;
		end
		if (k != slot_next[tag] || cycle != slot_accept[tag] + k + 1) begin
			$display("block %s column %0d arrived at cycle %0d, expected cycle %0d",
				slot_name[tag], k, cycle, slot_accept[tag] + k + 1);
			slot_bad[tag] = 1'b1;
		end
		expected = {tag[2:0], slot_words[tag][k]};
		if (column_decisions[k] !== expected) begin
			$display("Mismatch %s column %0d expected 0x%h actual 0x%h", slot_name[tag], k,
				expected, column_decisions[k]);
			slot_bad[tag] = 1'b1;
		end
		slot_next[tag] = k + 1;
		if (k == pipeline_pkg::num_columns - 1) begin
			if (path_metrics !== slot_metrics[tag]) begin
				$display("Mismatch %s final metrics expected 0x%h actual 0x%h",
					slot_name[tag], slot_metrics[tag], path_metrics);
				slot_bad[tag] = 1'b1;
			end
			finish_block(tag);
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (reset_q && column_valid != '0) begin
			$display("column_valid not cleared by reset: %b", column_valid);
			error_count++;
		end
		for (int k = 0; k < pipeline_pkg::num_columns; k++)
			if (column_valid[k])
				check_column(k);
		if (reset || reset_q) begin
			for (int t = 0; t < 8; t++) begin
				if (busy_tags[t]) begin
					$display("%s discarded by reset", slot_name[t]);
					busy_tags[t] = 1'b0;
				end
			end
		end
		// next column overdue
		for (int t = 0; t < 8; t++) begin
			if (busy_tags[t] && cycle > slot_accept[t] + slot_next[t] + 1) begin
				$display("block %s never produced column %0d output", slot_name[t],
					slot_next[t]);
				slot_bad[t] = 1'b1;
				finish_block(t);
			end
		end
	end

endmodule

// File: test/viterbi_acs_array_tb.sv
`timescale 1ns/100ps

module viterbi_acs_array_tb;

	localparam int max_patterns = 32;
	localparam int drain_limit = 40;
	localparam int tag_wait_limit = 20;

	logic clk;
	logic reset;
	logic input_valid;
	pipeline_pkg::block_tag_t block_tag;
	trellis_pkg::symbol_t [pipeline_pkg::num_columns-1:0] block_symbols;
	pipeline_pkg::column_decision_t [pipeline_pkg::num_columns-1:0] column_decisions;
	logic [pipeline_pkg::num_columns-1:0] column_valid;
	pipeline_pkg::metric_t [trellis_pkg::num_states-1:0] path_metrics;

	logic [7:0] busy_tags;
	int pass_count;
	int fail_count;
	int error_count;
	int tb_errors;

	string pat_name [max_patterns];
	logic [2:0] pat_tag [max_patterns];
	logic [7:0][1:0] pat_syms [max_patterns];
	logic [7:0][11:0] pat_words [max_patterns];
	logic [3:0][6:0] pat_metrics [max_patterns];
	int pat_count;

	viterbi_acs_array dut (
		.clk(clk),
		.reset(reset),
		.input_valid(input_valid),
		.block_tag(block_tag),
		.block_symbols(block_symbols),
		.column_decisions(column_decisions),
		.column_valid(column_valid),
		.path_metrics(path_metrics)
	);

	decision_checker u_decision_checker (
		.clk(clk),
		.reset(reset),
		.column_decisions(column_decisions),
		.column_valid(column_valid),
		.path_metrics(path_metrics),
		.busy_tags(busy_tags),
		.pass_count(pass_count),
		.fail_count(fail_count),
		.error_count(error_count)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// inputs change 10 ns after the rising edge
	task automatic step;
		@(posedge clk);
		#10;
	endtask

	task automatic idle(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			input_valid = 1'b0;
			step();
		end
	endtask

	task automatic send(input int idx);
		input_valid = 1'b1;
		block_tag = pat_tag[idx];
		block_symbols = pat_syms[idx];
		u_decision_checker.expect_block(pat_name[idx], pat_tag[idx], pat_words[idx],
			pat_metrics[idx]);
		step();
	endtask

	task automatic wait_tag_free(input logic [2:0] tag);
		int waited;
		waited = 0;
		while (busy_tags[tag] && waited < tag_wait_limit) begin
			input_valid = 1'b0;
			step();
			waited++;
		end
		if (busy_tags[tag]) begin
			$display("timed out waiting for tag %0d to come free", tag);
			tb_errors++;
		end
	endtask

	task automatic drain;
		int waited;
		waited = 0;
		input_valid = 1'b0;
		while (busy_tags != '0 && waited < drain_limit) begin
			step();
			waited++;
		end
		if (busy_tags != '0) begin
			$display("timed out waiting for blocks in flight to finish");
			tb_errors++;
		end
	endtask

	task automatic load_patterns;
		int fd;
		int n;
		int f [21];
		string line;
		string name;
		fd = $fopen("test/acs_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open test/acs_patterns.txt");
			tb_errors++;
			return;
		end
		while (!$feof(fd) && pat_count < max_patterns) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line,
				"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
				f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
			if (n != 22) begin
				$display("malformed line in pattern file: %s", line);
				tb_errors++;
				continue;
			end
			pat_name[pat_count] = name;
			pat_tag[pat_count] = f[0];
			for (int k = 0; k < 8; k++) begin
				pat_syms[pat_count][k] = f[1 + k];
				pat_words[pat_count][k] = f[9 + k];
			end
			// file lists final metrics from state 3 down to 0
			for (int s = 0; s < 4; s++)
				pat_metrics[pat_count][3 - s] = f[17 + s];
			pat_count++;
		end
		$fclose(fd);
	endtask

	initial begin
		int gap;
		void'($urandom(8));
		reset = 1'b1;
		input_valid = 1'b0;
		block_tag = '0;
		block_symbols = '0;
		tb_errors = 0;
		pat_count = 0;
		load_patterns();
		if (pat_count < 4) begin
			$display("pattern file holds too few blocks");
			tb_errors++;
		end
		repeat (5) @(posedge clk);
		#10;
		reset = 1'b0;
		step();

		for (int i = 0; i < pat_count; i++) begin
			gap = $urandom % 4;
			idle(gap);
			wait_tag_free(pat_tag[i]);
			send(i);
		end
		drain();

		// blocks in flight when reset hits are dropped
		if (pat_count >= 4) begin
			send(0);
			send(1);
			send(2);
			idle(2);
			reset = 1'b1;
			idle(2);
			reset = 1'b0;
			idle(1);
			send(3);
			drain();
		end
		idle(3);

		$display("tests passed: %0d, failed: %0d, other errors: %0d", pass_count, fail_count,
			error_count + tb_errors);
		if (fail_count == 0 && error_count == 0 && tb_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: test/acs_patterns.txt
# name tag sym0..sym7 (column 0 first) word0..word7 (12-bit decisions, state 3 high)
# then final metrics for states 3 2 1 0; all numbers hex
zero_block_a 0 0 0 0 0 0 0 0 0 8e0 8e0 8e0 820 820 820 820 820 3 2 3 0
codeword_clean_a 1 3 2 0 1 1 3 3 2 823 e20 8e0 820 838 efb 820 820 2 3 0 3
codeword_flip_a 2 3 2 0 0 1 3 3 2 823 e20 8e0 8e0 838 823 820 820 3 4 1 4
ones_block_a 3 3 3 3 3 3 3 3 3 823 823 823 823 823 823 823 823 3 2 3 3
zero_block_b 4 0 0 0 0 0 0 0 0 8e0 8e0 8e0 820 820 820 820 820 3 2 3 0
codeword_clean_b 5 3 2 0 1 1 3 3 2 823 e20 8e0 820 838 efb 820 820 2 3 0 3
codeword_flip_b 6 3 2 0 0 1 3 3 2 823 e20 8e0 8e0 838 823 820 820 3 4 1 4
ones_block_b 7 3 3 3 3 3 3 3 3 823 823 823 823 823 823 823 823 3 2 3 3
codeword_clean_c 0 3 2 0 1 1 3 3 2 823 e20 8e0 820 838 efb 820 820 2 3 0 3
codeword_flip_c 1 3 2 0 0 1 3 3 2 823 e20 8e0 8e0 838 823 820 820 3 4 1 4
ones_block_c 2 3 3 3 3 3 3 3 3 823 823 823 823 823 823 823 823 3 2 3 3
zero_block_c 3 0 0 0 0 0 0 0 0 8e0 8e0 8e0 820 820 820 820 820 3 2 3 0

// File: viterbi_acs_array.f
source/trellis_pkg.sv
source/pipeline_pkg.sv
source/acs_unit.sv
source/acs_column.sv
source/viterbi_acs_array.sv
test/decision_checker.sv
test/viterbi_acs_array_tb.sv

// File: Bender.yml
package:
  name: viterbi_acs_array

sources:
  - files:
      - source/trellis_pkg.sv
      - source/pipeline_pkg.sv
      - source/acs_unit.sv
      - source/acs_column.sv
      - source/viterbi_acs_array.sv
  - target: test
    files:
      - test/decision_checker.sv
      - test/viterbi_acs_array_tb.sv
